//--- dv/axi_demux_assert.sv
// Concurrent assertions on the demultiplexer handshakes and routing, bound into the top
`timescale 1ns/100ps
`default_nettype none

module axi_demux_assert
    import demux_pkg::*;
(
    input wire           clk,
    input wire           rstn,
    input wire sub_vec_t sub_aw_valid,
    input wire sub_vec_t sub_ar_valid,
    input wire           b_valid,
    input wire           b_ready,
    input wire           r_valid,
    input wire           r_ready
);

    // An address request is steered to one subordinate only
    a_aw_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(sub_aw_valid))
        else $error("sub_aw_valid has more than one bit set");

    a_ar_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(sub_ar_valid))
        else $error("sub_ar_valid has more than one bit set");

    // A pending write response stays up until the manager takes it
    a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
        b_valid && !b_ready |=> b_valid)
        else $error("b_valid dropped before b_ready");

    // The R path only presents a beat while the manager can take it
    a_r_ready: assert property (@(posedge clk) disable iff (!rstn) r_valid |-> r_ready)
        else $error("r_valid high while r_ready low");

endmodule

`default_nettype wire

//--- dv/tb_axi_demux.sv
// Testbench for the AXI demultiplexer with random manager traffic and modelled subordinates
`timescale 1ns/100ps
`default_nettype none

module tb_axi_demux
    import axi_chan_pkg::*;
    import demux_pkg::*;
;

    localparam int NUM_TXN = 200;
    // Forty cycles per transaction plus a margin
    localparam int CYCLE_LIMIT = 2 * NUM_TXN * 40 + 1000;

    typedef struct packed {
        id_t      id;
        addr_t    addr;
        len_t     len;
        sub_idx_t sub;
    } burst_t;

    typedef struct packed {
        sub_idx_t sub;
        data_t    data;
        logic     last;
    } wexp_t;

    logic clk;
    logic rstn;
    addr_req_t aw_req, ar_req;
    logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic ar_valid, ar_ready, r_valid, r_ready;
    w_beat_t w_beat;
    b_rsp_t b_rsp;
    r_beat_t r_beat;
    addr_req_t [SUB_NUM-1:0] sub_aw_req, sub_ar_req;
    w_beat_t [SUB_NUM-1:0] sub_w_beat;
    b_rsp_t [SUB_NUM-1:0] sub_b_rsp;
    r_beat_t [SUB_NUM-1:0] sub_r_beat;
    sub_vec_t sub_aw_valid, sub_aw_ready, sub_w_valid, sub_w_ready;
    sub_vec_t sub_b_valid, sub_b_ready, sub_ar_valid, sub_ar_ready;
    sub_vec_t sub_r_valid, sub_r_ready, b_took, r_took;

    // Reference model state
    burst_t aw_exp [$];
    burst_t ar_exp [$];
    wexp_t w_exp [$];
    sub_idx_t b_exp [ID_NUM][$];
    burst_t r_exp [ID_NUM][$];
    int m_beat [ID_NUM];
    // Subordinate state
    id_t w_id [SUB_NUM][$];
    b_rsp_t b_q [SUB_NUM][$];
    burst_t r_q [SUB_NUM][$];
    int r_cnt [SUB_NUM];
    int errors = 0;
    int cycles = 0;

    axi_demux i_axi_demux (.*);

    bind axi_demux axi_demux_assert i_axi_demux_assert (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Expected subordinate from the address map, lowest hit wins, no hit means 0
    function automatic sub_idx_t decode(addr_t a);
        for (int i = 0; i < SUB_NUM; i++) begin
            if ((SUB_MASK[i] != '0) && ((a & ~SUB_MASK[i]) == SUB_BASE[i])) begin
                return sub_idx_t'(i);
            end
        end
        return '0;
    endfunction

    function automatic int pending();
        int n;
        n = aw_exp.size() + ar_exp.size() + w_exp.size();
        for (int i = 0; i < ID_NUM; i++) begin
            n += b_exp[i].size() + r_exp[i].size();
        end
        return n;
    endfunction

    task automatic report_fail(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic run_writes();
        burst_t bt;
        wexp_t we;
        for (int n = 0; n < NUM_TXN; n++) begin
            bt.id = id_t'($urandom % 4);
            bt.addr = addr_t'($urandom);
            bt.len = len_t'($urandom % 4);
            bt.sub = decode(bt.addr);
            aw_exp.push_back(bt);
            b_exp[bt.id].push_back(bt.sub);
            @(negedge clk);
            aw_req = '{id: bt.id, addr: bt.addr, len: bt.len};
            aw_valid = 1'b1;
            do @(posedge clk); while (!aw_ready);
            @(negedge clk);
            aw_valid = 1'b0;
            for (int b = 0; b <= bt.len; b++) begin
                we.sub = bt.sub;
                we.data = $urandom;
                we.last = (b == bt.len);
                w_exp.push_back(we);
                w_beat = '{data: we.data, last: we.last};
                w_valid = 1'b1;
                do @(posedge clk); while (!w_ready);
                @(negedge clk);
                w_valid = 1'b0;
            end
        end
    endtask

    task automatic run_reads();
        burst_t bt;
        for (int n = 0; n < NUM_TXN; n++) begin
            bt.id = id_t'($urandom % 4);
            bt.addr = addr_t'($urandom);
            bt.len = len_t'($urandom % 4);
            bt.sub = decode(bt.addr);
            ar_exp.push_back(bt);
            r_exp[bt.id].push_back(bt);
            @(negedge clk);
            ar_req = '{id: bt.id, addr: bt.addr, len: bt.len};
            ar_valid = 1'b1;
            do @(posedge clk); while (!ar_ready);
            @(negedge clk);
            ar_valid = 1'b0;
            repeat ($urandom % 3) @(negedge clk);
        end
    endtask

    // Subordinates and manager readies are driven on the falling edge
    always @(negedge clk) begin
        if (rstn) begin
            b_ready = $urandom % 2;
            r_ready = $urandom % 2;
            for (int i = 0; i < SUB_NUM; i++) begin
                sub_aw_ready[i] = $urandom % 2;
                sub_w_ready[i] = $urandom % 2;
                sub_ar_ready[i] = $urandom % 2;
                if (b_took[i]) begin
                    sub_b_valid[i] = 1'b0;
                end
                if (!sub_b_valid[i] && b_q[i].size() > 0 && $urandom % 3 == 0) begin
                    sub_b_valid[i] = 1'b1;
                    sub_b_rsp[i] = b_q[i][0];
                end
                if (r_took[i]) begin
                    sub_r_valid[i] = 1'b0;
                end
                if (!sub_r_valid[i] && r_q[i].size() > 0 && $urandom % 3 == 0) begin
                    sub_r_valid[i] = 1'b1;
                    sub_r_beat[i] = '{id: r_q[i][0].id, resp: resp_t'(i),
                        data: {8'(i), 8'(r_cnt[i]), r_q[i][0].addr},
                        last: (r_cnt[i] == r_q[i][0].len)};
                end
            end
            b_took = '0;
            r_took = '0;
        end
    end

    // Handshakes are sampled on the rising edge before any register updates
    always @(posedge clk) begin
        burst_t bt;
        wexp_t we;
        data_t exp_data;
        if (rstn) begin
            cycles++;
            if (r_valid && !r_ready) report_fail("r_valid high while r_ready low");
            for (int i = 0; i < SUB_NUM; i++) begin
                if (sub_aw_valid[i] && sub_aw_ready[i]) begin
                    bt = aw_exp.pop_front();
                    if (bt.sub != i || sub_aw_req[i] != addr_req_t'{bt.id, bt.addr, bt.len})
                        report_fail($sformatf("AW at sub %0d, expected sub %0d", i, bt.sub));
                    w_id[i].push_back(bt.id);
                end
                if (sub_w_valid[i] && sub_w_ready[i]) begin
                    we = w_exp.pop_front();
                    if (we.sub != i || sub_w_beat[i] != w_beat_t'{we.data, we.last})
                        report_fail($sformatf("W beat at sub %0d, expected sub %0d", i, we.sub));
                    if (sub_w_beat[i].last && w_id[i].size() > 0)
                        b_q[i].push_back(b_rsp_t'{id: w_id[i].pop_front(), resp: resp_t'(i)});
                end
                if (sub_b_valid[i] && sub_b_ready[i]) begin
                    void'(b_q[i].pop_front());
                    b_took[i] = 1'b1;
                end
                if (sub_ar_valid[i] && sub_ar_ready[i]) begin
                    bt = ar_exp.pop_front();
                    if (bt.sub != i || sub_ar_req[i] != addr_req_t'{bt.id, bt.addr, bt.len})
                        report_fail($sformatf("AR at sub %0d, expected sub %0d", i, bt.sub));
                    r_q[i].push_back(bt);
                end
                if (sub_r_valid[i] && sub_r_ready[i]) begin
                    r_took[i] = 1'b1;
                    if (r_cnt[i] == r_q[i][0].len) begin
                        void'(r_q[i].pop_front());
                        r_cnt[i] = 0;
                    end else begin
                        r_cnt[i]++;
                    end
                end
            end
            if (b_valid && b_ready) begin
                if (b_exp[b_rsp.id].size() == 0) begin
                    report_fail($sformatf("unexpected B for id %0d", b_rsp.id));
                end else if (b_rsp.resp != resp_t'(b_exp[b_rsp.id].pop_front())) begin
                    report_fail($sformatf("B id %0d has resp %0d", b_rsp.id, b_rsp.resp));
                end
            end
            if (r_valid && r_ready) begin
                if (r_exp[r_beat.id].size() == 0) begin
                    report_fail($sformatf("unexpected R for id %0d", r_beat.id));
                end else begin
                    bt = r_exp[r_beat.id][0];
                    exp_data = {8'(bt.sub), 8'(m_beat[bt.id]), bt.addr};
                    if (r_beat.data != exp_data || r_beat.resp != resp_t'(bt.sub) ||
                        r_beat.last != (m_beat[bt.id] == bt.len))
                        report_fail($sformatf("R id %0d data %h resp %0d, expected %h",
                            r_beat.id, r_beat.data, r_beat.resp, exp_data));
                    if (r_beat.last) begin
                        void'(r_exp[bt.id].pop_front());
                        m_beat[bt.id] = 0;
                    end else begin
                        m_beat[bt.id]++;
                    end
                end
            end
            if (cycles > CYCLE_LIMIT) begin
                $display("The run did not finish within %0d cycles", CYCLE_LIMIT);
                errors++;
                $display("Run ended with %0d errors", errors);
                $display("Test failures found");
                $finish;
            end
        end
    end

    initial begin
        void'($urandom(32'h90737d66));
        rstn = 1'b0;
        {aw_req, aw_valid, w_beat, w_valid, b_ready, ar_req, ar_valid, r_ready} = '0;
        {sub_aw_ready, sub_w_ready, sub_b_valid, sub_ar_ready, sub_r_valid} = '0;
        sub_b_rsp = '0;
        sub_r_beat = '0;
        b_took = '0;
        r_took = '0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        // Idle outputs after reset
        if (aw_ready || w_ready || b_valid || ar_ready || r_valid || (|sub_aw_valid) ||
            (|sub_w_valid) || (|sub_b_ready) || (|sub_ar_valid) || (|sub_r_ready))
            report_fail("valid or ready output high after reset");
        fork
            run_writes();
            run_reads();
        join
        while (pending() > 0) @(posedge clk);
        $display("Run ended with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/addr_decoder.sv
// Address decoder that maps a request address onto a subordinate index by base and mask
`timescale 1ns/100ps
`default_nettype none

module addr_decoder
    import axi_chan_pkg::*;
    import demux_pkg::*;
(
    input  wire addr_t addr,
    output sub_idx_t   sub
);

    // One hit flag per map entry
    sub_vec_t hit;

    always_comb begin
        for (int i = 0; i < SUB_NUM; i++) begin
            // An entry with an all-zero mask never matches
            hit[i] = (SUB_MASK[i] != '0) && ((addr & ~SUB_MASK[i]) == SUB_BASE[i]);
        end
    end

    // Walk from the top down so that the lowest hit wins
    // With no hit at all the request falls back to subordinate 0
    always_comb begin
        sub = '0;
        for (int i = SUB_NUM - 1; i >= 0; i--) begin
            if (hit[i]) begin
                sub = sub_idx_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/axi_chan_pkg.sv
// AXI channel field widths, field types and the packed payloads of each channel
`default_nettype none

package axi_chan_pkg;

    // Widths of the channel fields shared by the manager and subordinate ports
    localparam int ID_W   = 3;
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int LEN_W  = 4;
    localparam int RESP_W = 2;

    typedef logic [ID_W-1:0]   id_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [RESP_W-1:0] resp_t;

    // Address request, the same layout serves AW and AR
    typedef struct packed {
        id_t   id;
        addr_t addr;
        // Number of beats in the burst minus one
        len_t  len;
    } addr_req_t;

    // One write data beat
    typedef struct packed {
        data_t data;
        logic  last;
    } w_beat_t;

    // Write response
    typedef struct packed {
        id_t   id;
        resp_t resp;
    } b_rsp_t;

    // One read data beat
    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
        logic  last;
    } r_beat_t;

endpackage

`default_nettype wire

//--- rtl/axi_demux.sv
// AXI demultiplexer top that joins one manager port to four subordinate ports
`timescale 1ns/100ps
`default_nettype none

module axi_demux
    import axi_chan_pkg::*;
    import demux_pkg::*;
(
    input  wire                        clk,
    input  wire                        rstn,
    // Manager port
    input  wire addr_req_t             aw_req,
    input  wire                        aw_valid,
    output logic                       aw_ready,
    input  wire w_beat_t               w_beat,
    input  wire                        w_valid,
    output logic                       w_ready,
    output b_rsp_t                     b_rsp,
    output logic                       b_valid,
    input  wire                        b_ready,
    input  wire addr_req_t             ar_req,
    input  wire                        ar_valid,
    output logic                       ar_ready,
    output r_beat_t                    r_beat,
    output logic                       r_valid,
    input  wire                        r_ready,
    // Subordinate ports, one element per subordinate
    output addr_req_t [SUB_NUM-1:0]    sub_aw_req,
    output sub_vec_t                   sub_aw_valid,
    input  wire sub_vec_t              sub_aw_ready,
    output w_beat_t [SUB_NUM-1:0]      sub_w_beat,
    output sub_vec_t                   sub_w_valid,
    input  wire sub_vec_t              sub_w_ready,
    input  wire b_rsp_t [SUB_NUM-1:0]  sub_b_rsp,
    input  wire sub_vec_t              sub_b_valid,
    output sub_vec_t                   sub_b_ready,
    output addr_req_t [SUB_NUM-1:0]    sub_ar_req,
    output sub_vec_t                   sub_ar_valid,
    input  wire sub_vec_t              sub_ar_ready,
    input  wire r_beat_t [SUB_NUM-1:0] sub_r_beat,
    input  wire sub_vec_t              sub_r_valid,
    output sub_vec_t                   sub_r_ready
);

    // Writes and reads share nothing, so the two routers run fully in parallel
    write_router i_write_router (
        .clk, .rstn,
        .aw_req, .aw_valid, .aw_ready,
        .w_beat, .w_valid, .w_ready,
        .b_rsp, .b_valid, .b_ready,
        .sub_aw_req, .sub_aw_valid, .sub_aw_ready,
        .sub_w_beat, .sub_w_valid, .sub_w_ready,
        .sub_b_rsp, .sub_b_valid, .sub_b_ready
    );

    read_router i_read_router (
        .clk, .rstn,
        .ar_req, .ar_valid, .ar_ready,
        .r_beat, .r_valid, .r_ready,
        .sub_ar_req, .sub_ar_valid, .sub_ar_ready,
        .sub_r_beat, .sub_r_valid, .sub_r_ready
    );

endmodule

`default_nettype wire

//--- rtl/demux_pkg.sv
// Demultiplexer definitions for the subordinate address map and the per-ID ordering tables
`default_nettype none

package demux_pkg;

    import axi_chan_pkg::*;

    // Four subordinates, addressed by a two bit index
    localparam int SUB_NUM = 4;
    localparam int SUB_W   = 2;

    typedef logic [SUB_W-1:0]   sub_idx_t;
    typedef logic [SUB_NUM-1:0] sub_vec_t;

    // Each subordinate owns one 16 KiB window of the address space
    localparam addr_t SUB_BASE [SUB_NUM] = '{16'h0000, 16'h4000, 16'h8000, 16'hC000};
    // A zero mask would disable the entry
    localparam addr_t SUB_MASK [SUB_NUM] = '{16'h3FFF, 16'h3FFF, 16'h3FFF, 16'h3FFF};

    // One table entry per possible transaction ID
    localparam int ID_NUM = 2**ID_W;
    // At most three transactions of one ID may be outstanding
    localparam int CNT_W  = 2;

    typedef logic [CNT_W-1:0] cnt_t;

    // Subordinate an ID is bound to and its outstanding count
    typedef struct packed {
        sub_idx_t sub;
        cnt_t     cnt;
    } map_entry_t;

endpackage

`default_nettype wire

//--- rtl/id_order_table.sv
// Per-ID ordering table that binds each ID to one subordinate while transactions are outstanding
`timescale 1ns/100ps
`default_nettype none

module id_order_table
    import axi_chan_pkg::*;
    import demux_pkg::*;
(
    input  wire           clk,
    input  wire           rstn,
    // Request side, looked up and counted up on acceptance
    input  wire id_t      req_id,
    input  wire sub_idx_t req_sub,
    input  wire           req_fire,
    // Completion side, counted down on the final response
    input  wire id_t      done_id,
    input  wire           done_fire,
    output logic          permit
);

    map_entry_t             map_q [ID_NUM];
    map_entry_t             lookup;
    logic      [ID_NUM-1:0] incr;
    logic      [ID_NUM-1:0] decr;

    assign lookup = map_q[req_id];

    // A free entry may be rebound to any subordinate
    // A busy entry only accepts more traffic to the same subordinate, up to the counter limit
    assign permit = (lookup.cnt == '0) ||
                    ((lookup.sub == req_sub) && (lookup.cnt != '1));

    // Decode the two events into one-hot per-entry strobes
    always_comb begin
        for (int i = 0; i < ID_NUM; i++) begin
            incr[i] = req_fire && (req_id == id_t'(i));
            decr[i] = done_fire && (done_id == id_t'(i));
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < ID_NUM; i++) begin
                map_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < ID_NUM; i++) begin
                if (incr[i]) begin
                    // Rebinding is harmless when the entry is already bound here
                    map_q[i].sub <= req_sub;
                    // A completion on the same ID in the same cycle cancels the increment
                    if (!decr[i]) begin
                        map_q[i].cnt <= map_q[i].cnt + 1'b1;
                    end
                end else if (decr[i]) begin
                    map_q[i].cnt <= map_q[i].cnt - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/read_router.sv
// Read path of the demultiplexer that steers AR under a lock and returns R combinationally
`timescale 1ns/100ps
`default_nettype none

module read_router
    import axi_chan_pkg::*;
    import demux_pkg::*;
(
    input  wire                        clk,
    input  wire                        rstn,
    // Manager side
    input  wire addr_req_t             ar_req,
    input  wire                        ar_valid,
    output logic                       ar_ready,
    output r_beat_t                    r_beat,
    output logic                       r_valid,
    input  wire                        r_ready,
    // Subordinate side
    output addr_req_t [SUB_NUM-1:0]    sub_ar_req,
    output sub_vec_t                   sub_ar_valid,
    input  wire sub_vec_t              sub_ar_ready,
    input  wire r_beat_t [SUB_NUM-1:0] sub_r_beat,
    input  wire sub_vec_t              sub_r_valid,
    output sub_vec_t                   sub_r_ready
);

    sub_idx_t ar_dec;
    logic     ar_permit;
    logic     ar_fwd;
    logic     ar_fire;
    logic     r_done;
    logic     ar_lock;
    sub_idx_t ar_sel;
    sub_vec_t r_grant;
    sub_idx_t r_grant_idx;

    addr_decoder i_ar_decoder (
        .addr (ar_req.addr),
        .sub  (ar_dec)
    );

    assign ar_fire = ar_valid && ar_ready;
    // A read burst completes with its last beat
    assign r_done  = r_valid && r_ready && r_beat.last;

    id_order_table i_read_table (
        .clk       (clk),
        .rstn      (rstn),
        .req_id    (ar_req.id),
        .req_sub   (ar_dec),
        .req_fire  (ar_fire),
        .done_id   (r_beat.id),
        .done_fire (r_done),
        .permit    (ar_permit)
    );

    assign ar_fwd = ar_valid && ar_permit && !ar_lock;

    // Same one cycle latency as AW, the latched index steers until the handshake
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ar_lock <= 1'b0;
            ar_sel  <= '0;
        end else if (ar_lock) begin
            if (ar_ready) begin
                ar_lock <= 1'b0;
            end
        end else if (ar_fwd) begin
            ar_lock <= 1'b1;
            ar_sel  <= ar_dec;
        end
    end

    assign ar_ready = ar_lock && sub_ar_ready[ar_sel];

    // Arbitrating only while r_ready is high means every grant completes in the same cycle
    // so nothing has to be held and no subordinate can be starved
    rr_arbiter i_r_arbiter (
        .clk       (clk),
        .rstn      (rstn),
        .enable    (r_ready),
        .request   (sub_r_valid),
        .grant     (r_grant),
        .grant_idx (r_grant_idx)
    );

    for (genvar i = 0; i < SUB_NUM; i++) begin : g_steer
        assign sub_ar_req[i]   = ar_req;
        assign sub_ar_valid[i] = ar_lock && (ar_sel == sub_idx_t'(i));
        assign sub_r_ready[i]  = r_ready && r_grant[i];
    end

    // Combinational path from r_ready to r_valid, to be broken outside if needed
    assign r_valid = r_ready && (|r_grant);
    assign r_beat  = sub_r_beat[r_grant_idx];

endmodule

`default_nettype wire

//--- rtl/rr_arbiter.sv
// Round-robin arbiter over the subordinate requests with a rotating priority pointer
`timescale 1ns/100ps
`default_nettype none

module rr_arbiter
    import demux_pkg::*;
(
    input  wire           clk,
    input  wire           rstn,
    input  wire           enable,
    input  wire sub_vec_t request,
    output sub_vec_t      grant,
    output sub_idx_t      grant_idx
);

    // Index of the most recent winner, the search starts just after it
    sub_idx_t last_win;

    always_comb begin : pick
        sub_idx_t cand;
        logic     found;
        grant     = '0;
        grant_idx = '0;
        found     = 1'b0;
        // Offsets 1 to SUB_NUM visit every index once, the last winner comes last
        for (int k = 1; k <= SUB_NUM; k++) begin
            cand = last_win + sub_idx_t'(k);
            if (!found && request[cand]) begin
                found       = 1'b1;
                grant[cand] = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    // The pointer only moves when the grant is actually used
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            // Start so that subordinate 0 has the highest priority
            last_win <= '1;
        end else if (enable && (|grant)) begin
            last_win <= grant_idx;
        end
    end

endmodule

`default_nettype wire

//--- rtl/write_router.sv
// Write path of the demultiplexer that steers AW and W under locks and returns arbitrated B
`timescale 1ns/100ps
`default_nettype none

module write_router
    import axi_chan_pkg::*;
    import demux_pkg::*;
(
    input  wire                       clk,
    input  wire                       rstn,
    // Manager side
    input  wire addr_req_t            aw_req,
    input  wire                       aw_valid,
    output logic                      aw_ready,
    input  wire w_beat_t              w_beat,
    input  wire                       w_valid,
    output logic                      w_ready,
    output b_rsp_t                    b_rsp,
    output logic                      b_valid,
    input  wire                       b_ready,
    // Subordinate side
    output addr_req_t [SUB_NUM-1:0]   sub_aw_req,
    output sub_vec_t                  sub_aw_valid,
    input  wire sub_vec_t             sub_aw_ready,
    output w_beat_t [SUB_NUM-1:0]     sub_w_beat,
    output sub_vec_t                  sub_w_valid,
    input  wire sub_vec_t             sub_w_ready,
    input  wire b_rsp_t [SUB_NUM-1:0] sub_b_rsp,
    input  wire sub_vec_t             sub_b_valid,
    output sub_vec_t                  sub_b_ready
);

    sub_idx_t aw_dec;
    logic     aw_permit;
    logic     aw_fwd;
    logic     aw_fire;
    logic     b_fire;
    logic     aw_lock;
    logic     w_lock;
    sub_idx_t aw_sel;
    logic     b_arb_en;
    sub_vec_t b_grant;
    sub_idx_t b_grant_idx;
    logic     b_lock;
    sub_idx_t b_sel;

    addr_decoder i_aw_decoder (
        .addr (aw_req.addr),
        .sub  (aw_dec)
    );

    assign aw_fire = aw_valid && aw_ready;
    assign b_fire  = b_valid && b_ready;

    // Writes are bound per ID until their B response has been returned
    id_order_table i_write_table (
        .clk       (clk),
        .rstn      (rstn),
        .req_id    (aw_req.id),
        .req_sub   (aw_dec),
        .req_fire  (aw_fire),
        .done_id   (b_rsp.id),
        .done_fire (b_fire),
        .permit    (aw_permit)
    );

    // A new burst is only taken once the previous AW and its W beats are both done
    assign aw_fwd = aw_valid && aw_permit && !aw_lock && !w_lock;

    // AW and W carry separate locks because W may run ahead of or behind AW
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            aw_lock <= 1'b0;
            w_lock  <= 1'b0;
            aw_sel  <= '0;
        end else if (aw_lock || w_lock) begin
            if (aw_ready) begin
                aw_lock <= 1'b0;
            end
            if (w_valid && w_ready && w_beat.last) begin
                w_lock <= 1'b0;
            end
        end else if (aw_fwd) begin
            aw_lock <= 1'b1;
            w_lock  <= 1'b1;
            aw_sel  <= aw_dec;
        end
    end

    // Payloads fan out to all subordinates, only the valid bits are steered
    for (genvar i = 0; i < SUB_NUM; i++) begin : g_steer
        assign sub_aw_req[i]   = aw_req;
        assign sub_aw_valid[i] = aw_lock && (aw_sel == sub_idx_t'(i));
        assign sub_w_beat[i]   = w_beat;
        assign sub_w_valid[i]  = w_lock && (aw_sel == sub_idx_t'(i)) && w_valid;
        assign sub_b_ready[i]  = b_lock && (b_sel == sub_idx_t'(i)) && b_ready;
    end

    // aw_valid is known to be high while the AW lock is set
    assign aw_ready = aw_lock && sub_aw_ready[aw_sel];
    assign w_ready  = w_lock && sub_w_ready[aw_sel];

    // Arbitrate only while no response is being held towards the manager
    assign b_arb_en = !b_lock;

    rr_arbiter i_b_arbiter (
        .clk       (clk),
        .rstn      (rstn),
        .enable    (b_arb_en),
        .request   (sub_b_valid),
        .grant     (b_grant),
        .grant_idx (b_grant_idx)
    );

    // The winner is latched so the response stays stable until b_ready
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            b_lock <= 1'b0;
            b_sel  <= '0;
        end else if (b_lock) begin
            if (b_ready) begin
                b_lock <= 1'b0;
            end
        end else if (|b_grant) begin
            b_lock <= 1'b1;
            b_sel  <= b_grant_idx;
        end
    end

    assign b_valid = b_lock;
    assign b_rsp   = sub_b_rsp[b_sel];

endmodule

`default_nettype wire

//--- src.f
rtl/axi_chan_pkg.sv
rtl/demux_pkg.sv
rtl/addr_decoder.sv
rtl/id_order_table.sv
rtl/rr_arbiter.sv
rtl/write_router.sv
rtl/read_router.sv
rtl/axi_demux.sv
dv/axi_demux_assert.sv
dv/tb_axi_demux.sv
